// File: hw/adxl_spi_pkg.sv
// ADXL355 SPI framing constants and the shared pin bundle
// one SCLK, CSn and MOSI fan out to both chips, MISO is per chip
package adxl_spi_pkg;

  // byte and burst geometry
  localparam int CMD_W  = 8;                // command byte, also the data byte width
  localparam int LEN_W  = 4;                // burst length in bytes incl command
  localparam int SLOT_W = 4;                // 16 clk_en ticks per byte, 2 per bit
  localparam int IDX_W  = LEN_W + SLOT_W;   // frame index = {byte slot, tick in slot}

  // landmarks inside the frame index
  localparam int TICK_CSN_LOW = 1;          // csn falls here
  localparam int TICK_SCLK_ON = 2;          // sclk gate opens, cmd loaded to mosi
  localparam int TAIL_TICKS   = 4;          // ticks after last slot until frame done

  // pins toward the chip pair, same layout for host and sequencer
  typedef struct packed {
    logic mosi;                             // shared data out
    logic sclk;                             // shared clock, idles low
    logic csn;                              // shared select, active low
  } spi_pins_t;

endpackage

// File: hw/acq_pkg.sv
// Acquisition side definitions: tag characters, buffer sizes,
// the byte event from the SPI sequencer and the block-RAM write bundle
package acq_pkg;

  // 6-bit NMEA style tag characters
  typedef logic [5:0] tag_char_t;

  localparam tag_char_t TAG_PULSE_CHAR = 6'h21;   // "!" marks a tag pulse
  localparam tag_char_t TAG_IDLE_CHAR  = 6'h20;   // space when nothing queued

  localparam int TAG_ADDR_BITS     = 11;                  // tag FIFO address bits
  localparam int TAG_DEPTH         = 2**TAG_ADDR_BITS;    // chars held by tag FIFO
  localparam int TAG_BITS_PER_CHIP = 3;                   // chip 0 low half, chip 1 high half

  localparam int CH1_BUF_DEPTH = 6;                       // chip 1 bytes held for replay

  // one write toward the byte-wide block RAM
  typedef struct packed {
    logic [7:0] data;
    logic       wr;                         // every data byte of chip 0
    logic       wr16;                       // 16-bit view, third byte of a triple skipped
    logic       x;                          // first x-axis byte of the frame
  } bram_wr_t;

  // completed byte pair, flags are one-clk strobes
  typedef struct packed {
    logic [7:0] d0;                         // chip 0 byte
    logic [7:0] d1;                         // chip 1 byte
    logic [6:0] byte_no;                    // 0 is the command slot
    logic       first_x;                    // byte 1 of the burst
    logic       wr_en;                      // any data byte
    logic       wr16_en;                    // data byte kept in 16-bit view
  } byte_evt_t;

endpackage

// File: hw/sync_fifo.sv
// Single-clock circular FIFO with a typed payload
// pop data is registered and shows up the clk after the pop
module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];            // storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;                  // entries held
  logic             do_push;
  logic             do_pop;

  // wraps at DEPTH, so non power of two sizes work too
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);   // full and no pop -> write is lost

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
    if (do_pop)
      pop_data <= mem[rd_ptr];              // head leaves on the same edge it is popped
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;            // none, or both at once
      endcase
    end
  end

  // the owner must look at empty before it pops
  pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("sync_fifo pop while empty");

endmodule

// File: hw/tag_source.sv
// Tag character source: buffers tagger chars in a FIFO and hands
// out one latched char per frame, a pending pulse overrides the FIFO
module tag_source (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               tag_pulse,    // one clk, queue a "!" for the next frame
  input  logic               tag_en,       // one clk, push tag into the FIFO
  input  acq_pkg::tag_char_t tag,
  input  logic               frame_start,
  output acq_pkg::tag_char_t tag_char      // held for the whole frame
);
  acq_pkg::tag_char_t fifo_head;           // popped char, one clk after the pop
  logic               fifo_empty;
  logic               fifo_pop;
  logic               pulse_pend;          // tag_pulse seen, not yet sent
  logic               from_fifo;           // take fifo_head on this clk

  // FIFO only gives a char when no pulse is waiting
  assign fifo_pop = frame_start && !pulse_pend && !fifo_empty;

  sync_fifo #(
    .payload_t (acq_pkg::tag_char_t),
    .DEPTH     (acq_pkg::TAG_DEPTH)
  ) u_tag_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (tag_en),
    .push_data (tag),
    .pop       (fifo_pop),
    .pop_data  (fifo_head),
    .empty     (fifo_empty),
    .full      ()                          // overflow just drops chars
  );

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pulse_pend <= 1'b0;
    else if (tag_pulse)
      pulse_pend <= 1'b1;                  // a new pulse beats the clear
    else if (frame_start)
      pulse_pend <= 1'b0;                  // consumed by this frame
  end

  // select order at frame start: pulse, FIFO head, space
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tag_char  <= acq_pkg::TAG_IDLE_CHAR;
      from_fifo <= 1'b0;
    end
    else
    begin
      from_fifo <= fifo_pop;
      if (frame_start && pulse_pend)
        tag_char <= acq_pkg::TAG_PULSE_CHAR;
      else if (frame_start && fifo_empty)
        tag_char <= acq_pkg::TAG_IDLE_CHAR;
      else if (from_fifo)
        tag_char <= fifo_head;             // registered FIFO read lands one clk later
    end
  end

endmodule

// File: hw/spi_burst_seq.sv
// SPI burst sequencer for the ADXL355 pair: frame index, pin timing,
// command shift out, dual MISO shift in, byte events and direct-mode grant
module spi_burst_seq (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           clk_en,     // one clk pulse per index step
  input  logic                           sync,       // start a burst when idle
  input  logic [adxl_spi_pkg::CMD_W-1:0] cmd,
  input  logic [adxl_spi_pkg::LEN_W-1:0] len,        // bytes incl command
  input  logic                           direct,     // host asks for the pins
  input  logic                           miso0,
  input  logic                           miso1,
  output adxl_spi_pkg::spi_pins_t        pins,
  output logic                           direct_en,  // host owns the pins
  output logic                           frame_start,
  output logic                           frame_done,
  output acq_pkg::byte_evt_t             evt
);
  localparam int IW = adxl_spi_pkg::IDX_W;
  localparam int SW = adxl_spi_pkg::SLOT_W;
  localparam int BW = adxl_spi_pkg::CMD_W;

  logic [IW-1:0]                  index;      // {byte slot, tick}, parks at idx_end
  logic [IW-1:0]                  idx_end;
  logic [adxl_spi_pkg::LEN_W-1:0] len_q;
  logic [BW-1:0]                  cmd_q;
  logic                           idle;
  logic                           start;
  logic                           tick;       // clk_en inside a frame
  logic                           bit_tick;   // even ticks, sclk falls, miso sampled
  logic                           csn_q;
  logic                           sclk_q;
  logic                           sclk_en;
  logic [BW-1:0]                  mosi_sr;
  logic [BW-1:0]                  ring;       // one-hot bit position within a byte
  logic [BW-1:0]                  sr0;
  logic [BW-1:0]                  sr1;
  logic [BW-1:0]                  nxt0;
  logic [BW-1:0]                  nxt1;
  logic                           byte_done;
  logic [6:0]                     byte_no;
  logic [1:0]                     trip;       // position inside an x/y/z triple

  assign idx_end   = {len_q, SW'(adxl_spi_pkg::TAIL_TICKS)};
  assign idle      = (index == idx_end);
  assign start     = idle && sync && !direct_en;   // sync mid-frame or in direct mode ignored
  assign tick      = clk_en && !idle;
  assign bit_tick  = tick && !index[0];
  assign nxt0      = {sr0[BW-2:0], miso0};
  assign nxt1      = {sr1[BW-2:0], miso1};
  assign byte_done = bit_tick && sclk_en && ring[BW-1];   // last bit of a byte sampled now
  assign byte_no   = 7'(index[IW-1:SW]) - 7'd1;           // slot n+1 closes byte n

  assign pins = '{mosi: mosi_sr[BW-1], sclk: sclk_q, csn: csn_q};

  // frame index and arbitration
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      index       <= IW'(adxl_spi_pkg::TAIL_TICKS);   // empty frame, already finished
      len_q       <= '0;
      direct_en   <= 1'b0;
      frame_start <= 1'b0;
      frame_done  <= 1'b0;
    end
    else
    begin
      frame_start <= start;
      frame_done  <= tick && (index == idx_end - 1'b1);
      if (start)
      begin
        index <= '0;
        len_q <= len;
      end
      else if (tick)
        index <= index + 1'b1;
      if (clk_en && idle && !start)
        direct_en <= direct;                // grant only moves between frames
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      cmd_q <= cmd;                         // held for the burst
  end

  // pin timing, one step per tick
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      csn_q   <= 1'b1;
      sclk_q  <= 1'b0;
      sclk_en <= 1'b0;
      mosi_sr <= '0;
      ring    <= '0;
    end
    else if (tick)
    begin
      if (index == IW'(adxl_spi_pkg::TICK_CSN_LOW))
        csn_q <= 1'b0;
      else if (index == {len_q, SW'(adxl_spi_pkg::TAIL_TICKS - 1)})
        csn_q <= 1'b1;                      // one tick after sclk stops
      if (index == IW'(adxl_spi_pkg::TICK_SCLK_ON))
        sclk_en <= 1'b1;
      else if (index == {len_q, SW'(adxl_spi_pkg::TICK_SCLK_ON)})
        sclk_en <= 1'b0;                    // 16 x len ticks later
      sclk_q <= sclk_en ? index[0] : 1'b0;  // high on odd ticks, mode 0
      if (!index[0])
      begin
        mosi_sr <= (index[IW-1:1] == 1) ? cmd_q : {mosi_sr[BW-2:0], 1'b0};   // MSB first
        ring    <= (index[IW-1:1] == 1) ? BW'(1) : {ring[BW-2:0], ring[BW-1]};
      end
    end
  end

  // MISO shift, both chips in step
  always_ff @(posedge clk)
  begin
    if (bit_tick)
    begin
      sr0 <= nxt0;
      sr1 <= nxt1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      trip <= '0;
    else if (start)
      trip <= '0;
    else if (byte_done && byte_no != '0)
      trip <= (trip == 2'd2) ? 2'd0 : trip + 1'b1;
  end

  // byte events, flags last one clk
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      evt.wr_en   <= 1'b0;
      evt.wr16_en <= 1'b0;
      evt.first_x <= 1'b0;
    end
    else
    begin
      evt.wr_en   <= byte_done && byte_no != '0;                 // command slot excluded
      evt.wr16_en <= byte_done && byte_no != '0 && trip != 2'd2; // drop third byte
      evt.first_x <= byte_done && byte_no == 7'd1;
    end
    if (byte_done)
    begin
      evt.d0      <= nxt0;
      evt.d1      <= nxt1;
      evt.byte_no <= byte_no;
    end
  end

  sclk_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(pins.sclk) |-> !pins.csn)
    else $error("sclk toggled with csn high");

  // the host mux in the top must never switch under an active select
  grant_between_frames: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(direct_en) |-> pins.csn && $past(pins.csn))
    else $error("direct_en changed inside a frame");

endmodule

// File: hw/sample_packer.sv
// Sample packer: stamps tag bits into the 16-bit view, writes chip 0
// to the block RAM as it arrives and replays chip 1 after the frame
module sample_packer (
  input  logic               clk,
  input  logic               rst_n,
  input  acq_pkg::byte_evt_t evt,
  input  acq_pkg::tag_char_t tag_char,
  input  logic               frame_start,
  input  logic               frame_done,
  output acq_pkg::bram_wr_t  bram
);
  localparam int TB = acq_pkg::TAG_BITS_PER_CHIP;
  localparam int IB = $clog2(TB + 1);

  logic              tag_on;                 // toggles on each wr16 byte
  logic [IB-1:0]     tag_idx;                // next tag bit per chip
  logic              tag_hit;
  logic [TB-1:0]     tag_lo;                 // chip 0 share of the char
  logic [TB-1:0]     tag_hi;                 // chip 1 share
  logic [7:0]        d0_tag;
  logic [7:0]        d1_tag;
  logic [7:0]        ch1_data;
  logic              ch1_empty;
  logic              ch1_pop;
  logic              replay_vld;             // ch1_data valid, drive a wr16
  acq_pkg::bram_wr_t bram_q;                 // chip 0 path

  assign tag_lo  = tag_char[TB-1:0];
  assign tag_hi  = tag_char[2*TB-1:TB];
  assign tag_hit = evt.wr16_en && tag_on && (tag_idx < IB'(TB));   // every other wr16 byte
  assign d0_tag  = tag_hit ? {evt.d0[7:1], tag_lo[tag_idx]} : evt.d0;
  assign d1_tag  = tag_hit ? {evt.d1[7:1], tag_hi[tag_idx]} : evt.d1;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tag_on  <= 1'b0;
      tag_idx <= '0;
    end
    else if (frame_start)
    begin
      tag_on  <= 1'b0;                       // first wr16 byte of a frame stays clean
      tag_idx <= '0;
    end
    else if (evt.wr16_en)
    begin
      tag_on <= !tag_on;
      if (tag_hit)
        tag_idx <= tag_idx + 1'b1;
    end
  end

  // chip 1 waits here until chip 0 is done
  sync_fifo #(
    .payload_t (logic [7:0]),
    .DEPTH     (acq_pkg::CH1_BUF_DEPTH)
  ) u_ch1_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (evt.wr16_en),
    .push_data (d1_tag),
    .pop       (ch1_pop),
    .pop_data  (ch1_data),
    .empty     (ch1_empty),
    .full      ()                            // one frame never overfills at len 10
  );

  // drain back to back from the clk after frame_done
  assign ch1_pop = (frame_done || replay_vld) && !ch1_empty;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      replay_vld  <= 1'b0;
      bram_q.wr   <= 1'b0;
      bram_q.wr16 <= 1'b0;
      bram_q.x    <= 1'b0;
    end
    else
    begin
      replay_vld  <= ch1_pop;
      bram_q.wr   <= evt.wr_en;
      bram_q.wr16 <= evt.wr16_en;
      bram_q.x    <= evt.first_x;              // rides with the first wr
    end
    if (evt.wr_en)
      bram_q.data <= d0_tag;
  end

  assign bram = replay_vld ? '{data: ch1_data, wr: 1'b0, wr16: 1'b1, x: 1'b0} : bram_q;

  no_ch0_in_replay: assert property (@(posedge clk) disable iff (!rst_n)
    replay_vld |-> !bram_q.wr)
    else $error("chip 0 write collided with chip 1 replay");

  // sequencer marks triples, packer relies on the skip for tag spacing
  wr16_skips_third: assert property (@(posedge clk) disable iff (!rst_n)
    evt.wr16_en |-> (evt.byte_no % 3) != 0)
    else $error("wr16 on the third byte of a triple");

endmodule

// File: hw/adxl_reader_top.sv
// Buffered ADXL355 pair reader: SPI sequencer, tag source and packer,
// plus the mux that hands the chip pins to the host in direct mode
module adxl_reader_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           clk_en,
  input  logic                           direct,
  input  logic                           tag_pulse,
  input  logic                           tag_en,
  input  acq_pkg::tag_char_t             tag,
  input  logic                           sync,
  input  logic [adxl_spi_pkg::CMD_W-1:0] cmd,
  input  logic [adxl_spi_pkg::LEN_W-1:0] len,
  input  adxl_spi_pkg::spi_pins_t        host_pins,
  input  logic                           miso0,
  input  logic                           miso1,
  output adxl_spi_pkg::spi_pins_t        adxl,
  output logic                           direct_en,
  output acq_pkg::bram_wr_t              bram
);
  adxl_spi_pkg::spi_pins_t seq_pins;
  logic                    frame_start;
  logic                    frame_done;
  acq_pkg::byte_evt_t      evt;
  acq_pkg::tag_char_t      tag_char;

  spi_burst_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .sync        (sync),
    .cmd         (cmd),
    .len         (len),
    .direct      (direct),
    .miso0       (miso0),
    .miso1       (miso1),
    .pins        (seq_pins),
    .direct_en   (direct_en),
    .frame_start (frame_start),
    .frame_done  (frame_done),
    .evt         (evt)
  );

  tag_source u_tag (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag_pulse   (tag_pulse),
    .tag_en      (tag_en),
    .tag         (tag),
    .frame_start (frame_start),
    .tag_char    (tag_char)
  );

  sample_packer u_pack (
    .clk         (clk),
    .rst_n       (rst_n),
    .evt         (evt),
    .tag_char    (tag_char),
    .frame_start (frame_start),
    .frame_done  (frame_done),
    .bram        (bram)
  );

  // host sees MISO directly, only the driven pins need the mux
  assign adxl = direct_en ? host_pins : seq_pins;

endmodule

// File: testbench/adxl_pair_model.sv
// Behavioral pair of ADXL355 SPI slaves sharing sclk, csn and mosi
// byte k answers k + 0x10 on chip 0 and k + 0x80 on chip 1, xor mask
module adxl_pair_model (
  input  logic       sclk,
  input  logic       csn,
  input  logic       mosi,
  input  logic [7:0] mask,                 // payload scramble, 0 gives the plain pattern
  output logic       miso0,
  output logic       miso1,
  output logic [7:0] cmd_seen              // first byte clocked in on mosi
);
  timeunit 1ns;
  timeprecision 100ps;

  int         fall_no;                     // sclk falling edges since csn fell
  int         rise_no;                     // sclk rising edges since csn fell
  logic [7:0] cmd_sr;

  function automatic logic [7:0] reply(input int chip, input int k);
    logic [7:0] base;
    base = (chip == 0) ? 8'h10 : 8'h80;
    return (base + 8'(k)) ^ mask;
  endfunction

  // bit n of the burst, MSB first inside each byte
  task automatic drive_bit(input int n);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = reply(0, n / 8);
    b1 = reply(1, n / 8);
    miso0 = b0[7 - (n % 8)];
    miso1 = b1[7 - (n % 8)];
  endtask

  initial
  begin
    miso0    = 1'b0;
    miso1    = 1'b0;
    cmd_seen = '0;
    cmd_sr   = '0;
    fall_no  = 0;
    rise_no  = 0;
  end

  always @(negedge csn)
  begin
    fall_no = 0;
    rise_no = 0;
    drive_bit(0);                          // first bit ready before the first sclk
  end

  // mode 0, master data valid on the rising edge
  always @(posedge sclk)
  begin
    if (csn == 1'b0)
    begin
      if (rise_no < 8)
        cmd_sr = {cmd_sr[6:0], mosi};
      rise_no++;
      if (rise_no == 8)
        cmd_seen = cmd_sr;
    end
  end

  // shift out on the falling edge, after the reader has sampled
  always @(negedge sclk)
  begin
    if (csn == 1'b0)
    begin
      fall_no++;
      drive_bit(fall_no);
    end
  end

endmodule

// File: testbench/tb_adxl_reader.sv
// Directed testbench for the ADXL355 pair reader: SPI framing, block-RAM
// strobes, tag stamping, chip 1 replay and direct host mode
module tb_adxl_reader;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_FRAMES     = 9;
  localparam int TIMEOUT_CLKS = 6 * (N_FRAMES * 16 * 12 * 4);
  localparam int SETTLE_CLKS  = acq_pkg::CH1_BUF_DEPTH + 3;   // frame_done to replay end
  localparam int HOLD_CLKS    = 160;       // 40 ticks, past where byte 1 would land

  logic                    clk;
  logic                    rst_n;
  logic                    clk_en;
  logic                    direct;
  logic                    tag_pulse;
  logic                    tag_en;
  acq_pkg::tag_char_t      tag;
  logic                    sync;
  logic [7:0]              cmd;
  logic [3:0]              len;
  adxl_spi_pkg::spi_pins_t host_pins;
  logic                    miso0;
  logic                    miso1;
  adxl_spi_pkg::spi_pins_t adxl;
  logic                    direct_en;
  acq_pkg::bram_wr_t       bram;
  logic [7:0]              pat_mask;
  logic [7:0]              cmd_seen;
  logic [1:0]              en_div;
  int                      cycles;
  int                      errors;
  int                      checks;
  int unsigned             rng_state;
  logic [7:0]              wr_q[$];       // chip 0 writes
  logic [7:0]              w16_q[$];      // wr16 inside the frame
  logic [7:0]              rep_q[$];      // wr16 replay of chip 1
  int                      x_pos[$];      // wr index where x was seen
  int                      sclk_rises;
  int                      sclk_bad;
  int                      csn_falls;
  int                      csn_rises;
  logic                    prev_sclk;
  logic                    prev_csn;

  adxl_reader_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .clk_en    (clk_en),
    .direct    (direct),
    .tag_pulse (tag_pulse),
    .tag_en    (tag_en),
    .tag       (tag),
    .sync      (sync),
    .cmd       (cmd),
    .len       (len),
    .host_pins (host_pins),
    .miso0     (miso0),
    .miso1     (miso1),
    .adxl      (adxl),
    .direct_en (direct_en),
    .bram      (bram)
  );

  adxl_pair_model model (
    .sclk     (adxl.sclk),
    .csn      (adxl.csn),
    .mosi     (adxl.mosi),
    .mask     (pat_mask),
    .miso0    (miso0),
    .miso1    (miso1),
    .cmd_seen (cmd_seen)
  );

  always #20 clk = ~clk;

  always @(posedge clk)                    // one strobe every 4 clks
  begin
    #2;
    en_div = en_div + 2'd1;
    clk_en = (en_div == 2'd0);
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CLKS)
    begin
      $display("timeout: no end of run after %0d clks, a frame never finished", cycles);
      $display("errors: %0d checks: %0d", errors, checks);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // log strobes and pin edges away from the active edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (bram.wr)
      begin
        if (bram.x)
          x_pos.push_back(wr_q.size());
        wr_q.push_back(bram.data);
      end
      else if (bram.x)
        x_pos.push_back(-1);               // x with no chip 0 write
      if (bram.wr16 && bram.wr)
        w16_q.push_back(bram.data);
      else if (bram.wr16)
        rep_q.push_back(bram.data);
      if (adxl.sclk && !prev_sclk)
      begin
        sclk_rises++;
        if (adxl.csn)
          sclk_bad++;
      end
      if (!adxl.csn && prev_csn)
        csn_falls++;
      if (adxl.csn && !prev_csn)
        csn_rises++;
    end
    prev_sclk = adxl.sclk;
    prev_csn  = adxl.csn;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [7:0] lcg_byte();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[23:16];
  endfunction

  // byte k of a chip as written, tag bit in bit 0 of every other wr16 byte
  function automatic logic [7:0] expect_byte(input int chip, input int k,
                                             input acq_pkg::tag_char_t t,
                                             input logic [7:0] m);
    logic [7:0] b;
    b = ((chip == 0 ? 8'h10 : 8'h80) + 8'(k)) ^ m;
    if (k % 3 == 2 && k / 3 < 3)
      b[0] = t[3 * chip + k / 3];          // chip 0 bits 0..2, chip 1 bits 3..5
    return b;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_logs();
    wr_q.delete();
    w16_q.delete();
    rep_q.delete();
    x_pos.delete();
    sclk_rises = 0;
    sclk_bad   = 0;
    csn_falls  = 0;
    csn_rises  = 0;
  endtask

  task automatic push_tag(input acq_pkg::tag_char_t c);
    tag    = c;
    tag_en = 1'b1;
    next_cycle();
    tag_en = 1'b0;
  endtask

  task automatic send_pulse();
    tag_pulse = 1'b1;
    next_cycle();
    tag_pulse = 1'b0;
  endtask

  task automatic start_frame(input logic [7:0] c, input logic [3:0] n);
    clear_logs();
    cmd  = c;
    len  = n;
    sync = 1'b1;
    next_cycle();
    sync = 1'b0;
  endtask

  task automatic finish_frame();
    while (adxl.csn)
      next_cycle();                        // csn falls on tick 1
    while (!adxl.csn)
      next_cycle();
    repeat (SETTLE_CLKS) next_cycle();     // replay follows frame_done directly
  endtask

  task automatic verify_frame(input logic [7:0] c, input int n, input acq_pkg::tag_char_t t);
    logic [7:0]         exp16[$];
    logic [7:0]         exprep[$];
    acq_pkg::tag_char_t got_tag;
    int                 k;
    for (k = 1; k < n; k++)
    begin
      if (k % 3 != 0)
      begin
        exp16.push_back(expect_byte(0, k, t, pat_mask));
        exprep.push_back(expect_byte(1, k, t, pat_mask));
      end
    end
    check("cmd_seen", cmd_seen, c);
    check("csn_falls", csn_falls, 1);
    check("csn_rises", csn_rises, 1);
    check("sclk_rises", sclk_rises, 8 * n);
    check("sclk_with_csn_high", sclk_bad, 0);
    check("wr_count", wr_q.size(), n - 1);
    foreach (wr_q[i])
      check("wr_data", wr_q[i], expect_byte(0, i + 1, t, pat_mask));
    check("x_count", x_pos.size(), 1);
    if (x_pos.size() > 0)
      check("x_wr_index", x_pos[0], 0);
    check("wr16_count", w16_q.size(), exp16.size());
    foreach (w16_q[i])
    begin
      if (i < exp16.size())
        check("wr16_data", w16_q[i], exp16[i]);
    end
    check("replay_count", rep_q.size(), exprep.size());
    foreach (rep_q[i])
    begin
      if (i < exprep.size())
        check("replay_data", rep_q[i], exprep[i]);
    end
    if (wr_q.size() == 9 && rep_q.size() == 6)
    begin
      got_tag = {rep_q[5][0], rep_q[3][0], rep_q[1][0], wr_q[7][0], wr_q[4][0], wr_q[1][0]};
      check("tag_char", got_tag, t);       // rebuilt from bit 0 of the tagged bytes
    end
  endtask

  task automatic run_frame(input logic [7:0] c, input int n, input acq_pkg::tag_char_t t);
    start_frame(c, 4'(n));
    finish_frame();
    verify_frame(c, n, t);
  endtask

  // command, framing, wr and wr16 strobes, then a scrambled shorter burst
  task automatic burst_framing();
    logic [7:0] c;
    pat_mask = 8'h00;
    run_frame(8'h11, 10, acq_pkg::TAG_IDLE_CHAR);
    pat_mask = lcg_byte();
    c        = lcg_byte();
    run_frame(c, 7, acq_pkg::TAG_IDLE_CHAR);
    pat_mask = 8'h00;
  endtask

  task automatic tag_fifo_order();
    push_tag(6'h01);                       // A
    push_tag(6'h02);                       // B
    run_frame(8'h11, 10, 6'h01);
    run_frame(8'h11, 10, 6'h02);
    run_frame(8'h11, 10, acq_pkg::TAG_IDLE_CHAR);   // FIFO drained
  endtask

  task automatic tag_pulse_override();
    acq_pkg::tag_char_t c;
    c        = 6'(lcg_byte());
    pat_mask = lcg_byte();
    push_tag(c);
    send_pulse();
    run_frame(8'h11, 10, acq_pkg::TAG_PULSE_CHAR);
    run_frame(8'h11, 10, c);               // queued char one frame later
    pat_mask = 8'h00;
  endtask

  task automatic direct_handover();
    int i;
    start_frame(8'h11, 4'd10);
    while (adxl.csn)
      next_cycle();
    direct = 1'b1;                         // request lands mid-frame
    while (!adxl.csn)
      next_cycle();
    check("direct_en_at_frame_end", direct_en, 0);
    repeat (SETTLE_CLKS) next_cycle();
    verify_frame(8'h11, 10, acq_pkg::TAG_IDLE_CHAR);
    while (!direct_en)
      next_cycle();
    clear_logs();
    sync = 1'b1;                           // must not start a frame now
    next_cycle();
    sync = 1'b0;
    for (i = 0; i < 8; i++)
    begin
      host_pins = adxl_spi_pkg::spi_pins_t'(3'(i));
      @(negedge clk);
      check("adxl_pins", adxl, host_pins);
      next_cycle();
    end
    host_pins = '{mosi: 1'b0, sclk: 1'b0, csn: 1'b1};
    repeat (HOLD_CLKS) next_cycle();
    check("wr_in_direct", wr_q.size(), 0);
    direct = 1'b0;
    while (direct_en)
      next_cycle();
    run_frame(8'h11, 10, acq_pkg::TAG_IDLE_CHAR);
  endtask

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    clk_en    = 1'b0;
    direct    = 1'b0;
    tag_pulse = 1'b0;
    tag_en    = 1'b0;
    tag       = '0;
    sync      = 1'b0;
    cmd       = '0;
    len       = '0;
    host_pins = '{mosi: 1'b0, sclk: 1'b0, csn: 1'b1};
    pat_mask  = 8'h00;
    en_div    = 2'd0;
    cycles    = 0;
    errors    = 0;
    checks    = 0;
    rng_state = 49;
    prev_sclk = 1'b0;
    prev_csn  = 1'b1;
    clear_logs();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    burst_framing();
    tag_fifo_order();
    tag_pulse_override();
    direct_handover();
    $display("errors: %0d checks: %0d", errors, checks);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: sim.f
hw/adxl_spi_pkg.sv
hw/acq_pkg.sv
hw/sync_fifo.sv
hw/tag_source.sv
hw/spi_burst_seq.sv
hw/sample_packer.sv
hw/adxl_reader_top.sv
testbench/adxl_pair_model.sv
testbench/tb_adxl_reader.sv
